//--- source/aquila_map_pkg.sv
`default_nettype none

package aquila_map_pkg;

    // -------------------------------------------------------------------------
    // Address segments, picked by the top nibble of the address
    // -------------------------------------------------------------------------

    // Response select codes for the routers
    typedef enum logic [1:0] {
        SEG_TCM = 2'd0,
        SEG_MEM = 2'd1,
        SEG_DEV = 2'd2,
        SEG_SYS = 2'd3
    } seg_e;

    // Top nibble codes, any other value is main memory
    localparam logic [3:0] SEG_TCM_NIBBLE = 4'h0;
    localparam logic [3:0] SEG_DEV_NIBBLE = 4'hC;
    localparam logic [3:0] SEG_SYS_NIBBLE = 4'hF;

    // Tightly coupled memory depth in words
    localparam int TCM_WORDS = 1024;
    localparam int TCM_AW    = $clog2(TCM_WORDS);

    // System device select field is addr[19:16], zero means the interruptor
    localparam int SYSDEV_SEL_LSB = 16;

    // Interruptor word offsets, taken from addr[4:2]
    localparam logic [2:0] CLINT_MSIP_W    = 3'd0;
    localparam logic [2:0] CLINT_CMP_LO_W  = 3'd2;
    localparam logic [2:0] CLINT_CMP_HI_W  = 3'd3;
    localparam logic [2:0] CLINT_TIME_LO_W = 3'd4;
    localparam logic [2:0] CLINT_TIME_HI_W = 3'd5;

endpackage

`default_nettype wire

//--- source/aquila_bus_pkg.sv
`default_nettype none

package aquila_bus_pkg;

    // -------------------------------------------------------------------------
    // Word bus between the core, the uncore and the outside world
    // -------------------------------------------------------------------------

    // Data word width
    localparam int XLEN = 32;

    // One enable per byte lane
    localparam int BE_W = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;

    // Data side request, 70 bits
    // Strobe is a single cycle pulse, rw high means write
    typedef struct packed {
        logic            strobe;
        logic            rw;
        word_t           addr;
        logic [BE_W-1:0] byte_en;
        word_t           wdata;
    } bus_req_t;

    // Response, 33 bits
    // Rdata is only meaningful in the cycle of the ready pulse
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } bus_rsp_t;

    // Instruction fetch request, 33 bits
    // Fetches are always full word reads
    typedef struct packed {
        logic  strobe;
        word_t addr;
    } fetch_req_t;

endpackage

`default_nettype wire

//--- source/tcm_dp.sv
`timescale 1ns/1ps
`default_nettype none

module tcm_dp
    import aquila_map_pkg::*, aquila_bus_pkg::*;
(
    input  wire                clk_i,

    // Port A, instruction side, read only
    input  wire                a_en_i,
    input  wire [TCM_AW-1:0]   a_addr_i,
    output word_t              a_rdata_o,
    output logic               a_ready_o,

    // Port B, data side, read or byte-enabled write
    input  wire                b_en_i,
    input  wire                b_we_i,
    input  wire [BE_W-1:0]     b_be_i,
    input  wire [TCM_AW-1:0]   b_addr_i,
    input  wire word_t         b_wdata_i,
    output word_t              b_rdata_o,
    output logic               b_ready_o
);

    // Word array, written only through port B
    word_t mem [TCM_WORDS];

    // -------------------------------------------------------------------------
    // Port A
    // -------------------------------------------------------------------------

    // Data and ready one cycle after the enable
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdata_o <= mem[a_addr_i];
        end
        a_ready_o <= a_en_i;
    end

    // -------------------------------------------------------------------------
    // Port B
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            // Merge only the enabled lanes
            if (b_we_i) begin
                for (int i = 0; i < BE_W; i++) begin
                    if (b_be_i[i]) begin
                        mem[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
                    end
                end
            end
            // Old word, also on a write
            b_rdata_o <= mem[b_addr_i];
        end
        b_ready_o <= b_en_i;
    end

endmodule

`default_nettype wire

//--- source/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint
    import aquila_map_pkg::*, aquila_bus_pkg::*;
(
    input  wire         clk_i,
    input  wire         arst_n_i,

    // Register access, one cycle strobe
    input  wire         en_i,
    input  wire         we_i,
    input  wire [2:0]   word_i,
    input  wire word_t  wdata_i,
    output word_t       rdata_o,
    output logic        ready_o,

    // Interrupt lines to the core
    output logic        tmr_irq_o,
    output logic        sft_irq_o
);

    // Software interrupt pending bit
    logic        msip_q;

    // Free-running time and its compare value
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;

    // Word selected by the current offset
    word_t       rd_word;

    // Write strobe for this cycle
    logic        wr_en;

    assign wr_en = en_i & we_i;

    // -------------------------------------------------------------------------
    // Read mux
    // -------------------------------------------------------------------------

    // Unmapped offsets read as zero
    always_comb begin
        case (word_i)
            CLINT_MSIP_W:    rd_word = {{(XLEN-1){1'b0}}, msip_q};
            CLINT_CMP_LO_W:  rd_word = mtimecmp_q[31:0];
            CLINT_CMP_HI_W:  rd_word = mtimecmp_q[63:32];
            CLINT_TIME_LO_W: rd_word = mtime_q[31:0];
            CLINT_TIME_HI_W: rd_word = mtime_q[63:32];
            default:         rd_word = '0;
        endcase
    end

    // Read data captured on the strobe, valid with ready
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= rd_word;
        end
    end

    // -------------------------------------------------------------------------
    // Registers
    // -------------------------------------------------------------------------

    // Compare at all ones keeps the timer interrupt quiet out of reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            msip_q     <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            ready_o    <= 1'b0;
        end else begin
            ready_o <= en_i;
            // Counts every cycle, a write to a time word overrides that half
            mtime_q <= mtime_q + 64'd1;
            if (wr_en) begin
                case (word_i)
                    CLINT_MSIP_W:    msip_q            <= wdata_i[0];
                    CLINT_CMP_LO_W:  mtimecmp_q[31:0]  <= wdata_i;
                    CLINT_CMP_HI_W:  mtimecmp_q[63:32] <= wdata_i;
                    CLINT_TIME_LO_W: mtime_q[31:0]     <= wdata_i;
                    CLINT_TIME_HI_W: mtime_q[63:32]    <= wdata_i;
                    default:         msip_q            <= msip_q;
                endcase
            end
        end
    end

    // Level interrupts
    assign tmr_irq_o = (mtime_q >= mtimecmp_q);
    assign sft_irq_o = msip_q;

endmodule

`default_nettype wire

//--- source/fetch_router.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_router
    import aquila_map_pkg::*, aquila_bus_pkg::*;
(
    input  wire                clk_i,
    input  wire                arst_n_i,

    // Core instruction port
    input  wire fetch_req_t    core_i_req_i,
    output bus_rsp_t           core_i_rsp_o,

    // Memory port A
    output logic               tcm_en_o,
    output logic [TCM_AW-1:0]  tcm_addr_o,
    input  wire word_t         tcm_rdata_i,
    input  wire                tcm_ready_i,

    // External instruction port
    output fetch_req_t         mem_i_req_o,
    input  wire bus_rsp_t      mem_i_rsp_i
);

    // Segment of this fetch, only memory or main memory here
    seg_e seg;

    // Segment of the last strobe
    seg_e sel_q;

    assign seg = (core_i_req_i.addr[XLEN-1 -: 4] == SEG_TCM_NIBBLE) ? SEG_TCM : SEG_MEM;

    // Gated strobes, word address into the memory
    assign tcm_en_o    = core_i_req_i.strobe & (seg == SEG_TCM);
    assign tcm_addr_o  = core_i_req_i.addr[TCM_AW+1:2];
    assign mem_i_req_o = (seg == SEG_MEM) ? core_i_req_i : '0;

    // Held until the next strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= SEG_MEM;
        end else if (core_i_req_i.strobe) begin
            sel_q <= seg;
        end
    end

    // Response back to the core
    assign core_i_rsp_o = (sel_q == SEG_TCM) ? '{ready: tcm_ready_i, rdata: tcm_rdata_i}
                                             : mem_i_rsp_i;

endmodule

`default_nettype wire

//--- source/data_router.sv
`timescale 1ns/1ps
`default_nettype none

module data_router
    import aquila_map_pkg::*, aquila_bus_pkg::*;
(
    input  wire                clk_i,
    input  wire                arst_n_i,

    // Core data port
    input  wire bus_req_t      core_d_req_i,
    output bus_rsp_t           core_d_rsp_o,

    // Memory port B
    output logic               tcm_en_o,
    output logic               tcm_we_o,
    output logic [BE_W-1:0]    tcm_be_o,
    output logic [TCM_AW-1:0]  tcm_addr_o,
    output word_t              tcm_wdata_o,
    input  wire word_t         tcm_rdata_i,
    input  wire                tcm_ready_i,

    // Interruptor
    output logic               clint_en_o,
    output logic               clint_we_o,
    output logic [2:0]         clint_word_o,
    output word_t              clint_wdata_o,
    input  wire word_t         clint_rdata_i,
    input  wire                clint_ready_i,

    // External main memory
    output bus_req_t           mem_d_req_o,
    input  wire bus_rsp_t      mem_d_rsp_i,

    // External devices
    output bus_req_t           dev_req_o,
    input  wire bus_rsp_t      dev_rsp_i
);

    // Decoded segment of the current request
    seg_e       seg;

    // Segment of the last strobe, drives the response mux
    seg_e       sel_q;

    // System device select field
    logic [3:0] sysdev_sel;

    // Interruptor window or the harmless rest of the system region
    logic       clint_hit;
    logic       nop_hit;

    // Ready for the harmless region, one cycle after its strobe
    logic       nop_ready_q;

    // -------------------------------------------------------------------------
    // Decode
    // -------------------------------------------------------------------------

    always_comb begin
        case (core_d_req_i.addr[XLEN-1 -: 4])
            SEG_TCM_NIBBLE: seg = SEG_TCM;
            SEG_DEV_NIBBLE: seg = SEG_DEV;
            SEG_SYS_NIBBLE: seg = SEG_SYS;
            default:        seg = SEG_MEM;
        endcase
    end

    assign sysdev_sel = core_d_req_i.addr[SYSDEV_SEL_LSB +: 4];
    assign clint_hit  = (seg == SEG_SYS) & (sysdev_sel == 4'h0);
    assign nop_hit    = (seg == SEG_SYS) & (sysdev_sel != 4'h0);

    // -------------------------------------------------------------------------
    // Forwarded requests, at most one strobe high
    // -------------------------------------------------------------------------

    // Memory, word addressed
    assign tcm_en_o    = core_d_req_i.strobe & (seg == SEG_TCM);
    assign tcm_we_o    = core_d_req_i.rw & (seg == SEG_TCM);
    assign tcm_be_o    = core_d_req_i.byte_en;
    assign tcm_addr_o  = core_d_req_i.addr[TCM_AW+1:2];
    assign tcm_wdata_o = core_d_req_i.wdata;

    // Interruptor, offset from addr[4:2]
    assign clint_en_o    = core_d_req_i.strobe & clint_hit;
    assign clint_we_o    = core_d_req_i.rw & clint_hit;
    assign clint_word_o  = core_d_req_i.addr[4:2];
    assign clint_wdata_o = core_d_req_i.wdata;

    // External ports see the request unchanged, or all zero
    assign mem_d_req_o = (seg == SEG_MEM) ? core_d_req_i : '0;
    assign dev_req_o   = (seg == SEG_DEV) ? core_d_req_i : '0;

    // -------------------------------------------------------------------------
    // Select register and harmless region
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q       <= SEG_MEM;
            nop_ready_q <= 1'b0;
        end else begin
            nop_ready_q <= core_d_req_i.strobe & nop_hit;
            if (core_d_req_i.strobe) begin
                sel_q <= seg;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Response mux
    // -------------------------------------------------------------------------

    // In the system region only one of the two readies can fire
    always_comb begin
        case (sel_q)
            SEG_TCM: core_d_rsp_o = '{ready: tcm_ready_i, rdata: tcm_rdata_i};
            SEG_MEM: core_d_rsp_o = mem_d_rsp_i;
            SEG_DEV: core_d_rsp_o = dev_rsp_i;
            default: begin
                core_d_rsp_o.ready = clint_ready_i | nop_ready_q;
                // Harmless region answers zero
                core_d_rsp_o.rdata = clint_ready_i ? clint_rdata_i : '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/aquila_uncore.sv
`timescale 1ns/1ps
`default_nettype none

module aquila_uncore
    import aquila_map_pkg::*, aquila_bus_pkg::*;
(
    input  wire             clk_i,
    input  wire             arst_n_i,

    // Core ports
    input  wire fetch_req_t core_i_req_i,
    output bus_rsp_t        core_i_rsp_o,
    input  wire bus_req_t   core_d_req_i,
    output bus_rsp_t        core_d_rsp_o,

    // Main memory, word wide and uncached
    output fetch_req_t      mem_i_req_o,
    input  wire bus_rsp_t   mem_i_rsp_i,
    output bus_req_t        mem_d_req_o,
    input  wire bus_rsp_t   mem_d_rsp_i,

    // Device space
    output bus_req_t        dev_req_o,
    input  wire bus_rsp_t   dev_rsp_i,

    // Interrupts to the core
    output logic            tmr_irq_o,
    output logic            sft_irq_o
);

    // Fetch side of the memory
    logic              i_tcm_en;
    logic [TCM_AW-1:0] i_tcm_addr;
    word_t             i_tcm_rdata;
    logic              i_tcm_ready;

    // Data side of the memory
    logic              d_tcm_en;
    logic              d_tcm_we;
    logic [BE_W-1:0]   d_tcm_be;
    logic [TCM_AW-1:0] d_tcm_addr;
    word_t             d_tcm_wdata;
    word_t             d_tcm_rdata;
    logic              d_tcm_ready;

    // Interruptor access
    logic              clint_en;
    logic              clint_we;
    logic [2:0]        clint_word;
    word_t             clint_wdata;
    word_t             clint_rdata;
    logic              clint_ready;

    // -------------------------------------------------------------------------
    // Routers
    // -------------------------------------------------------------------------

    fetch_router u_fetch_router (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .core_i_req_i (core_i_req_i),
        .core_i_rsp_o (core_i_rsp_o),
        .tcm_en_o     (i_tcm_en),
        .tcm_addr_o   (i_tcm_addr),
        .tcm_rdata_i  (i_tcm_rdata),
        .tcm_ready_i  (i_tcm_ready),
        .mem_i_req_o  (mem_i_req_o),
        .mem_i_rsp_i  (mem_i_rsp_i)
    );

    data_router u_data_router (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .core_d_req_i  (core_d_req_i),
        .core_d_rsp_o  (core_d_rsp_o),
        .tcm_en_o      (d_tcm_en),
        .tcm_we_o      (d_tcm_we),
        .tcm_be_o      (d_tcm_be),
        .tcm_addr_o    (d_tcm_addr),
        .tcm_wdata_o   (d_tcm_wdata),
        .tcm_rdata_i   (d_tcm_rdata),
        .tcm_ready_i   (d_tcm_ready),
        .clint_en_o    (clint_en),
        .clint_we_o    (clint_we),
        .clint_word_o  (clint_word),
        .clint_wdata_o (clint_wdata),
        .clint_rdata_i (clint_rdata),
        .clint_ready_i (clint_ready),
        .mem_d_req_o   (mem_d_req_o),
        .mem_d_rsp_i   (mem_d_rsp_i),
        .dev_req_o     (dev_req_o),
        .dev_rsp_i     (dev_rsp_i)
    );

    // -------------------------------------------------------------------------
    // Targets
    // -------------------------------------------------------------------------

    tcm_dp u_tcm (
        .clk_i     (clk_i),
        .a_en_i    (i_tcm_en),
        .a_addr_i  (i_tcm_addr),
        .a_rdata_o (i_tcm_rdata),
        .a_ready_o (i_tcm_ready),
        .b_en_i    (d_tcm_en),
        .b_we_i    (d_tcm_we),
        .b_be_i    (d_tcm_be),
        .b_addr_i  (d_tcm_addr),
        .b_wdata_i (d_tcm_wdata),
        .b_rdata_o (d_tcm_rdata),
        .b_ready_o (d_tcm_ready)
    );

    clint u_clint (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .en_i      (clint_en),
        .we_i      (clint_we),
        .word_i    (clint_word),
        .wdata_i   (clint_wdata),
        .rdata_o   (clint_rdata),
        .ready_o   (clint_ready),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

`default_nettype wire

//--- verification/aquila_uncore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module aquila_uncore_chk
    import aquila_bus_pkg::*;
(
    input  wire           clk_i,
    input  wire           arst_n_i,
    input  wire           tcm_en_o,
    input  wire           tcm_ready_i,
    input  wire           clint_en_o,
    input  wire           clint_ready_i,
    input  wire bus_req_t mem_d_req_o,
    input  wire bus_req_t dev_req_o
);

    // ------------------------------------------------------------------------
    // Routing rules on the data side
    // ------------------------------------------------------------------------

    // A data request reaches one target at most
    one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({tcm_en_o, clint_en_o, mem_d_req_o.strobe, dev_req_o.strobe}))
        else $error("more than one data target strobed");

    // Memory ready exactly one cycle after its strobe
    tcm_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tcm_ready_i == $past(tcm_en_o))
        else $error("memory ready not one cycle after strobe");

    // Interruptor ready exactly one cycle after its strobe
    clint_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        clint_ready_i == $past(clint_en_o))
        else $error("interruptor ready not one cycle after strobe");

endmodule

`default_nettype wire

//--- verification/aquila_uncore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aquila_uncore_tb
    import aquila_bus_pkg::*;
();

    // Expected response with check flag, fixed latency (0 means any) and data
    typedef struct packed {
        logic       chk;
        logic [3:0] lat;
        word_t      data;
    } exp_t;

    // Accesses issued by the stimulus, from the memory fill to the system region
    localparam int N_TXN     = 16 + 40 + 16 + 20 + 20 + 30 + 7 + 10;
    // Ten cycles per access plus margin for reset and the timer wait
    localparam int LIMIT_CYC = N_TXN * 10 + 300;

    logic       clk_i;
    logic       arst_n_i;
    fetch_req_t core_i_req_i;
    bus_rsp_t   core_i_rsp_o;
    bus_req_t   core_d_req_i;
    bus_rsp_t   core_d_rsp_o;
    fetch_req_t mem_i_req_o;
    bus_rsp_t   mem_i_rsp_i;
    bus_req_t   mem_d_req_o;
    bus_rsp_t   mem_d_rsp_i;
    bus_req_t   dev_req_o;
    bus_rsp_t   dev_rsp_i;
    logic       tmr_irq_o;
    logic       sft_irq_o;

    integer seed = 90;

    // Shadows for the reference and the models' own storage
    word_t  tcm_sh [1024];
    word_t  mem_sh [word_t];
    word_t  dev_sh [word_t];
    word_t  mdl_mem [word_t];
    word_t  mdl_dev [word_t];
    logic   msip_sh = 1'b0;

    // Last requests issued as they should reappear on the external ports
    bus_req_t last_d;
    word_t    last_i;

    exp_t   d_exp [$];
    exp_t   i_exp [$];

    aquila_uncore dut (.*);

    bind data_router aquila_uncore_chk u_chk (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic abort(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort("value mismatch");
        end
    endtask

    // Contents of main memory and devices before any write
    function automatic word_t mem_pattern(input word_t a);
        return a ^ 32'hA5A5_1234;
    endfunction

    function automatic word_t dev_pattern(input word_t a);
        return {a[15:0], a[31:16]} + 32'h0BAD_0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [3:0] be);
        word_t w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    function automatic word_t mem_value(input word_t a);
        return mem_sh.exists(a) ? mem_sh[a] : mem_pattern(a);
    endfunction

    function automatic word_t dev_value(input word_t a);
        return dev_sh.exists(a) ? dev_sh[a] : dev_pattern(a);
    endfunction

    // Reference read data of one access by segment
    function automatic exp_t expect_rdata(input word_t addr, input logic rw);
        exp_t e;
        e = '{chk: !rw, lat: 4'd1, data: '0};
        case (addr[31:28])
            4'h0: e.data = tcm_sh[addr[11:2]];
            4'hC: begin
                e.lat  = 4'd0;
                e.data = dev_value(addr);
            end
            4'hF: begin
                // Interruptor window decoded by offset while other selects read zero
                if (addr[19:16] == 4'h0) begin
                    case (addr[4:2])
                        3'd0:             e.data = {31'b0, msip_sh};
                        3'd1, 3'd6, 3'd7: e.data = '0;
                        default:          e.chk  = 1'b0;
                    endcase
                end
            end
            default: begin
                e.lat  = 4'd0;
                e.data = mem_value(addr);
            end
        endcase
        return e;
    endfunction

    function automatic void shadow_write(input word_t a, input logic [3:0] be,
                                         input word_t wd);
        case (a[31:28])
            4'h0: tcm_sh[a[11:2]] = merge_bytes(tcm_sh[a[11:2]], wd, be);
            4'hC: dev_sh[a] = merge_bytes(dev_value(a), wd, be);
            4'hF: begin
                if (a[19:16] == 4'h0 && a[4:2] == 3'd0) begin
                    msip_sh = wd[0];
                end
            end
            default: mem_sh[a] = merge_bytes(mem_value(a), wd, be);
        endcase
    endfunction

    // One data access that waits for its ready
    task automatic data_acc(input logic rw, input word_t addr, input logic [3:0] be,
                            input word_t wd, output word_t rd);
        d_exp.push_back(expect_rdata(addr, rw));
        if (rw) begin
            shadow_write(addr, be, wd);
        end
        last_d = '{strobe: 1'b1, rw: rw, addr: addr, byte_en: be, wdata: wd};
        @(posedge clk_i);
        core_d_req_i <= last_d;
        @(posedge clk_i);
        core_d_req_i <= '0;
        do @(negedge clk_i); while (!core_d_rsp_o.ready);
        rd = core_d_rsp_o.rdata;
    endtask

    task automatic fetch(input word_t addr);
        if (addr[31:28] == 4'h0) begin
            i_exp.push_back('{chk: 1'b1, lat: 4'd1, data: tcm_sh[addr[11:2]]});
        end else begin
            i_exp.push_back('{chk: 1'b1, lat: 4'd0, data: mem_value(addr)});
        end
        last_i = addr;
        @(posedge clk_i);
        core_i_req_i <= '{strobe: 1'b1, addr: addr};
        @(posedge clk_i);
        core_i_req_i <= '0;
        do @(negedge clk_i); while (!core_i_rsp_o.ready);
    endtask

    // ------------------------------------------------------------------------
    // External models with a random latency of 1 to 4 cycles
    // ------------------------------------------------------------------------

    initial begin : mem_d_model
        int    dly;
        word_t a;
        word_t r;
        mem_d_rsp_i <= '0;
        forever begin
            @(posedge clk_i);
            if (mem_d_req_o.strobe) begin
                a = mem_d_req_o.addr;
                check_val("dev_req_o busy", 32'(dev_req_o != '0), 32'd0);
                check_val("mem_d_req_o.addr", a, last_d.addr);
                check_val("mem_d_req_o.rw", 32'(mem_d_req_o.rw), 32'(last_d.rw));
                check_val("mem_d_req_o.wdata", mem_d_req_o.wdata, last_d.wdata);
                check_val("mem_d_req_o.byte_en", 32'(mem_d_req_o.byte_en),
                          32'(last_d.byte_en));
                r = mdl_mem.exists(a) ? mdl_mem[a] : mem_pattern(a);
                if (mem_d_req_o.rw) begin
                    mdl_mem[a] = merge_bytes(r, mem_d_req_o.wdata, mem_d_req_o.byte_en);
                end
                dly = 1 + ($unsigned($random(seed)) % 4);
                repeat (dly - 1) @(posedge clk_i);
                mem_d_rsp_i <= '{ready: 1'b1, rdata: r};
                @(posedge clk_i);
                mem_d_rsp_i <= '0;
            end
        end
    end

    initial begin : dev_model
        int    dly;
        word_t a;
        word_t r;
        dev_rsp_i <= '0;
        forever begin
            @(posedge clk_i);
            if (dev_req_o.strobe) begin
                a = dev_req_o.addr;
                check_val("mem_d_req_o busy", 32'(mem_d_req_o != '0), 32'd0);
                check_val("dev_req_o.addr", a, last_d.addr);
                check_val("dev_req_o.rw", 32'(dev_req_o.rw), 32'(last_d.rw));
                check_val("dev_req_o.wdata", dev_req_o.wdata, last_d.wdata);
                check_val("dev_req_o.byte_en", 32'(dev_req_o.byte_en),
                          32'(last_d.byte_en));
                r = mdl_dev.exists(a) ? mdl_dev[a] : dev_pattern(a);
                if (dev_req_o.rw) begin
                    mdl_dev[a] = merge_bytes(r, dev_req_o.wdata, dev_req_o.byte_en);
                end
                dly = 1 + ($unsigned($random(seed)) % 4);
                repeat (dly - 1) @(posedge clk_i);
                dev_rsp_i <= '{ready: 1'b1, rdata: r};
                @(posedge clk_i);
                dev_rsp_i <= '0;
            end
        end
    end

    initial begin : mem_i_model
        int    dly;
        word_t a;
        mem_i_rsp_i <= '0;
        forever begin
            @(posedge clk_i);
            if (mem_i_req_o.strobe) begin
                a = mem_i_req_o.addr;
                check_val("mem_i_req_o.addr", a, last_i);
                dly = 1 + ($unsigned($random(seed)) % 4);
                repeat (dly - 1) @(posedge clk_i);
                mem_i_rsp_i <= '{ready: 1'b1,
                                 rdata: mdl_mem.exists(a) ? mdl_mem[a] : mem_pattern(a)};
                @(posedge clk_i);
                mem_i_rsp_i <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Compare on every ready with latency counted from the strobe
    // ------------------------------------------------------------------------

    initial begin : compare
        int   d_cnt;
        int   i_cnt;
        exp_t e;
        d_cnt = 0;
        i_cnt = 0;
        forever begin
            @(negedge clk_i);
            d_cnt = core_d_req_i.strobe ? 0 : d_cnt + 1;
            i_cnt = core_i_req_i.strobe ? 0 : i_cnt + 1;
            if (arst_n_i && core_d_rsp_o.ready) begin
                if (d_exp.size() == 0) abort("data ready without a pending access");
                e = d_exp.pop_front();
                if (e.lat != 4'd0) check_val("core_d_rsp_o latency", 32'(d_cnt), 32'(e.lat));
                if (e.chk) check_val("core_d_rsp_o.rdata", core_d_rsp_o.rdata, e.data);
            end
            if (arst_n_i && core_i_rsp_o.ready) begin
                if (i_exp.size() == 0) abort("fetch ready without a pending fetch");
                e = i_exp.pop_front();
                if (e.lat != 4'd0) check_val("core_i_rsp_o latency", 32'(i_cnt), 32'(e.lat));
                if (e.chk) check_val("core_i_rsp_o.rdata", core_i_rsp_o.rdata, e.data);
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_CYC * 4);
        abort($sformatf("timeout: run did not finish within %0d cycles", LIMIT_CYC));
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        word_t      rnd;
        word_t      rd;
        word_t      t0;
        logic [3:0] nib;
        core_d_req_i <= '0;
        core_i_req_i <= '0;
        arst_n_i     <= 1'b0;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        // Full-word writes first so every byte of the window is known
        for (int i = 0; i < 16; i++) begin
            data_acc(1'b1, 32'(i * 4), 4'hF, $random(seed), rd);
        end
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            data_acc(rnd[8], {26'h0, rnd[3:0], 2'b00}, rnd[7:4], $random(seed), rd);
        end
        // Fetches out of the memory see the data side writes
        for (int i = 0; i < 16; i++) begin
            fetch(32'(i * 4));
        end
        // Fetch side and data side run at once
        fork
            begin : main_fetches
                word_t ra;
                for (int i = 0; i < 20; i++) begin
                    ra = $random(seed);
                    fetch({4'h1 + 4'($unsigned(ra[15:8]) % 11), 18'h0, ra[7:0], 2'b00});
                end
            end
            begin : dev_accesses
                word_t rb;
                word_t rdb;
                for (int i = 0; i < 20; i++) begin
                    rb = $random(seed);
                    data_acc(rb[8], {4'hC, 20'h0, rb[5:0], 2'b00}, rb[15:12],
                             $random(seed), rdb);
                end
            end
        join
        // Main memory over a small pool so reads hit earlier writes
        for (int i = 0; i < 30; i++) begin
            rnd = $random(seed);
            nib = 4'h1 + 4'($unsigned(rnd[15:8]) % 11);
            data_acc(rnd[16], {nib, 18'h0, 5'h0, rnd[2:0], 2'b00}, rnd[23:20],
                     $random(seed), rd);
        end
        // Software interrupt
        data_acc(1'b1, 32'hF000_0000, 4'hF, 32'd1, rd);
        check_val("sft_irq_o", 32'(sft_irq_o), 32'd1);
        data_acc(1'b0, 32'hF000_0000, 4'hF, '0, rd);
        data_acc(1'b0, 32'hF000_0004, 4'hF, '0, rd);
        data_acc(1'b1, 32'hF000_0000, 4'hF, 32'd0, rd);
        check_val("sft_irq_o", 32'(sft_irq_o), 32'd0);
        // Timer compare set a little above the time just read
        data_acc(1'b0, 32'hF000_0010, 4'hF, '0, t0);
        data_acc(1'b1, 32'hF000_000C, 4'hF, 32'd0, rd);
        data_acc(1'b1, 32'hF000_0008, 4'hF, t0 + 32'd30, rd);
        check_val("tmr_irq_o", 32'(tmr_irq_o), 32'd0);
        repeat (40) @(negedge clk_i);
        check_val("tmr_irq_o", 32'(tmr_irq_o), 32'd1);
        // Rest of the system region answers zero
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            data_acc(rnd[4], {4'hF, 8'h0, rnd[19:16] | 4'h1, 14'h0, 2'b00}, 4'hF,
                     $random(seed), rd);
        end
        repeat (4) @(negedge clk_i);
        if (d_exp.size() == 0 && i_exp.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort("responses missing at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- aquila_uncore.f
source/aquila_map_pkg.sv
source/aquila_bus_pkg.sv
source/tcm_dp.sv
source/clint.sv
source/fetch_router.sv
source/data_router.sv
source/aquila_uncore.sv
verification/aquila_uncore_chk.sv
verification/aquila_uncore_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the uncore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module aquila_uncore_tb \
    -f aquila_uncore.f

# The log decides, so a failing run must not stop the script here
./obj_dir/Vaquila_uncore_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
